// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_top \
		-f lsu_align.f --Mdir obj_dir -o Vtb_top
	./obj_dir/Vtb_top | tee $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: lsu_align.f
source/lsu_pkg.sv
source/lsu_request_gen.sv
source/lsu_txn_ctrl.sv
source/lsu_load_align.sv
source/lsu_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: source/lsu_load_align.sv
// Load data realignment, split assembly, zero/sign extension and bus error merge
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            resp_valid_i,
  input  wire wb_ctrl_t        head_ctrl_i,
  input  wire logic [xlen-1:0] data_rdata_i,
  input  wire logic            data_err_i,
  output logic                 rsp_valid_o,
  output logic [xlen-1:0]      rsp_rdata_o,
  output logic                 rsp_err_o
);

  // Low word of a split load
  logic [xlen-1:0]   rdata_q;
  // First part of a split has returned
  logic              first_q;
  // Error seen on the first part
  logic              err_q;
  logic [2*xlen-1:0] rdata_full;
  logic [2*xlen-1:0] rdata_shift;
  logic [xlen-1:0]   rdata_aligned;
  lsu_size_e         size;

  assign size = lsu_size_e'(head_ctrl_i.size);

  ////////////////////////////////////////////////////////////////////////////
  // First part capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (resp_valid_i && !head_ctrl_i.last && !head_ctrl_i.we) begin
      rdata_q <= data_rdata_i;
    end
  end

  // Stores also carry the error of their first part
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q <= 1'b0;
      err_q   <= 1'b0;
    end else if (resp_valid_i) begin
      if (head_ctrl_i.last) begin
        first_q <= 1'b0;
        err_q   <= 1'b0;
      end else begin
        first_q <= 1'b1;
        err_q   <= data_err_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Realignment and extension
  ////////////////////////////////////////////////////////////////////////////

  // Present response is the high word of a split
  // Unsplit data is doubled so the shift wraps lanes down
  assign rdata_full = first_q ? {data_rdata_i, rdata_q} : {data_rdata_i, data_rdata_i};

  assign rdata_shift   = rdata_full >> {head_ctrl_i.offset, 3'b000};
  assign rdata_aligned = rdata_shift[xlen-1:0];

  always_comb begin
    case (size)
      lsu_byte: begin
        rsp_rdata_o = {{24{head_ctrl_i.sext && rdata_aligned[7]}}, rdata_aligned[7:0]};
      end
      lsu_half: begin
        rsp_rdata_o = {{16{head_ctrl_i.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      end
      default: begin
        rsp_rdata_o = rdata_aligned;
      end
    endcase
  end

  // One completion per instruction on its last part
  assign rsp_valid_o = resp_valid_i && head_ctrl_i.last;
  assign rsp_err_o   = data_err_i || err_q;

endmodule

`default_nettype wire

// File: source/lsu_pkg.sv
// Widths, queue depth, size codes and the request, bus and control structs of the LSU
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and depth
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned xlen      = 32;
  localparam int unsigned be_w      = 4;
  // Maximum number of transfers in flight on the data bus
  localparam int unsigned lsu_depth = 2;
  // Outstanding counter must reach lsu_depth itself
  localparam int unsigned lsu_cnt_w = $clog2(lsu_depth + 1);
  localparam int unsigned lsu_ptr_w = $clog2(lsu_depth);

  // Access size codes as carried in the request
  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;
  localparam logic [1:0] size_word = 2'd2;

  typedef enum logic [1:0] {
    lsu_byte = size_byte,
    lsu_half = size_half,
    lsu_word = size_word
  } lsu_size_e;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  // One load or store from the execute stage
  typedef struct packed {
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic            we;
    logic [1:0]      size;
    logic            sext;
    logic [xlen-1:0] wdata;
  } lsu_req_t;

  // One OBI address phase
  typedef struct packed {
    logic [xlen-1:0] addr;
    logic            we;
    logic [be_w-1:0] be;
    logic [xlen-1:0] wdata;
  } bus_req_t;

  // Kept per transfer until its response returns
  typedef struct packed {
    logic       we;
    logic [1:0] size;
    logic       sext;
    logic [1:0] offset;
    logic       last;
  } wb_ctrl_t;

endpackage

`default_nettype wire

// File: source/lsu_request_gen.sv
// Address generation, split tracking, byte enables and write data lane rotation
`timescale 1ns/1ps
`default_nettype none

module lsu_request_gen import lsu_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     req_valid_i,
  input  wire lsu_req_t req_i,
  input  wire logic     part_done_i,
  output bus_req_t      bus_req_o,
  output wb_ctrl_t      wb_ctrl_o,
  output logic          split_o
);

  logic [xlen-1:0]   addr;
  logic [1:0]        offset;
  lsu_size_e         size;
  logic [be_w-1:0]   be;
  logic [2*xlen-1:0] wdata_dbl;
  // Second address phase of a split access in progress
  logic              split_q;

  // Effective address is base plus offset operand
  assign addr   = req_i.operand_a + req_i.operand_b;
  assign offset = addr[1:0];
  assign size   = lsu_size_e'(req_i.size);

  // Word not on a word boundary, or halfword crossing into the next word
  always_comb begin
    split_o = 1'b0;
    if (req_valid_i && !split_q) begin
      case (size)
        lsu_word: split_o = (offset != 2'b00);
        lsu_half: split_o = (offset == 2'b11);
        default:  split_o = 1'b0;
      endcase
    end
  end

  // Cleared while idle so a new instruction always starts on its first part
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!req_valid_i) begin
      split_q <= 1'b0;
    end else if (part_done_i) begin
      split_q <= split_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    be = '0;
    case (size)
      lsu_byte: be = 4'b0001 << offset;
      lsu_half: begin
        if (!split_q) begin
          case (offset)
            2'b00:   be = 4'b0011;
            2'b01:   be = 4'b0110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin
          // Only the top byte spills over
          be = 4'b0001;
        end
      end
      default: begin
        if (!split_q) begin
          be = 4'b1111 << offset;
        end else begin
          // Remaining low lanes of the next word
          be = 4'b1111 >> (3'd4 - {1'b0, offset});
        end
      end
    endcase
  end

  // Rotate write data so byte 0 lands in lane offset
  // Bytes that wrap around feed the second part of a split
  assign wdata_dbl = {req_i.wdata, req_i.wdata} << {offset, 3'b000};

  always_comb begin
    bus_req_o.we    = req_i.we;
    bus_req_o.be    = be;
    bus_req_o.wdata = wdata_dbl[2*xlen-1:xlen];
    // Second part goes to the next word boundary
    if (split_q) begin
      bus_req_o.addr = {addr[xlen-1:2], 2'b00} + xlen'(4);
    end else begin
      bus_req_o.addr = addr;
    end
  end

  // Load alignment uses the original offset for both parts
  always_comb begin
    wb_ctrl_o.we     = req_i.we;
    wb_ctrl_o.size   = req_i.size;
    wb_ctrl_o.sext   = req_i.sext;
    wb_ctrl_o.offset = offset;
    wb_ctrl_o.last   = !split_o;
  end

  a_size_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    req_valid_i |-> (req_i.size != 2'b11)
  );

endmodule

`default_nettype wire

// File: source/lsu_top.sv
// LSU top level joining request generation, bus control and load alignment
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst_n,
  // Execute side
  input  wire logic            req_valid_i,
  input  wire lsu_req_t        req_i,
  output logic                 req_ready_o,
  // OBI data bus
  output logic                 data_req_o,
  output bus_req_t             data_o,
  input  wire logic            data_gnt_i,
  input  wire logic            data_rvalid_i,
  input  wire logic [xlen-1:0] data_rdata_i,
  input  wire logic            data_err_i,
  // Write-back side
  output logic                 rsp_valid_o,
  output logic [xlen-1:0]      rsp_rdata_o,
  output logic                 rsp_err_o,
  // Status
  output logic                 busy_o,
  output logic                 interruptible_o
);

  bus_req_t bus_req;
  wb_ctrl_t wb_ctrl;
  wb_ctrl_t head_ctrl;
  logic     split;
  logic     part_done;
  logic     resp_valid;

  lsu_request_gen u_request_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .part_done_i (part_done),
    .bus_req_o   (bus_req),
    .wb_ctrl_o   (wb_ctrl),
    .split_o     (split)
  );

  lsu_txn_ctrl u_txn_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid_i     (req_valid_i),
    .bus_req_i       (bus_req),
    .wb_ctrl_i       (wb_ctrl),
    .split_i         (split),
    .data_req_o      (data_req_o),
    .data_o          (data_o),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .part_done_o     (part_done),
    .req_ready_o     (req_ready_o),
    .head_ctrl_o     (head_ctrl),
    .resp_valid_o    (resp_valid),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o)
  );

  lsu_load_align u_load_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .resp_valid_i (resp_valid),
    .head_ctrl_i  (head_ctrl),
    .data_rdata_i (data_rdata_i),
    .data_err_i   (data_err_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_err_o    (rsp_err_o)
  );

endmodule

`default_nettype wire

// File: source/lsu_txn_ctrl.sv
// OBI handshake, outstanding transfer queue, execute ready and busy/interruptible flags
`timescale 1ns/1ps
`default_nettype none

module lsu_txn_ctrl import lsu_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     req_valid_i,
  input  wire bus_req_t bus_req_i,
  input  wire wb_ctrl_t wb_ctrl_i,
  input  wire logic     split_i,
  output logic          data_req_o,
  output bus_req_t      data_o,
  input  wire logic     data_gnt_i,
  input  wire logic     data_rvalid_i,
  output logic          part_done_o,
  output logic          req_ready_o,
  output wb_ctrl_t      head_ctrl_o,
  output logic          resp_valid_o,
  output logic          busy_o,
  output logic          interruptible_o
);

  // Per-transfer control in grant order
  wb_ctrl_t             queue_q [lsu_depth];
  logic [lsu_ptr_w-1:0] wr_ptr_q;
  logic [lsu_ptr_w-1:0] rd_ptr_q;
  // Fill level equals the number of outstanding transfers
  logic [lsu_cnt_w-1:0] cnt_q;
  logic                 push;
  logic                 pop;
  // Request was held over a clock edge without grant
  logic                 req_pend_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////////////////////

  // Hold off new requests while the queue is full
  assign data_req_o = req_valid_i && (cnt_q < lsu_cnt_w'(lsu_depth));
  assign data_o     = bus_req_i;

  assign push        = data_req_o && data_gnt_i;
  assign pop         = data_rvalid_i;
  assign part_done_o = push;

  // Instruction leaves execute when its last part is granted
  assign req_ready_o = push && !split_i;

  ////////////////////////////////////////////////////////////////////////////
  // Tracking queue
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      queue_q[wr_ptr_q] <= wb_ctrl_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Grant and response in the same cycle leave the count as is
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Responses return in order so the oldest entry matches
  assign head_ctrl_o  = queue_q[rd_ptr_q];
  assign resp_valid_o = pop;

  ////////////////////////////////////////////////////////////////////////////
  // Status flags
  ////////////////////////////////////////////////////////////////////////////

  // A raised request may not be withdrawn
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_pend_q <= 1'b0;
    end else if (push) begin
      req_pend_q <= 1'b0;
    end else if (data_req_o) begin
      req_pend_q <= 1'b1;
    end
  end

  assign interruptible_o = !req_pend_q && (cnt_q == '0);
  assign busy_o          = data_req_o || (cnt_q != '0);

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0)
  );

  // OBI address phase must hold until granted
  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (data_req_o && !data_gnt_i) |=> (data_req_o && $stable(data_o))
  );

endmodule

`default_nettype wire

// File: testbench/tb_checker.sv
// Bus and completion checker with shadow memory and load reference model
`timescale 1ns/1ps
`default_nettype none

module bus_checker import lsu_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            req_valid_i,
  input  wire lsu_req_t        req_i,
  input  wire logic            req_ready_i,
  input  wire logic            data_req_i,
  input  wire bus_req_t        data_i,
  input  wire logic            data_gnt_i,
  input  wire logic            data_rvalid_i,
  input  wire logic            data_err_i,
  input  wire logic            rsp_valid_i,
  input  wire logic [xlen-1:0] rsp_rdata_i,
  input  wire logic            rsp_err_i,
  input  wire logic            busy_i,
  input  wire logic            interruptible_i,
  output int unsigned          err_cnt_o,
  output int unsigned          chk_cnt_o,
  output int unsigned          cons_cnt_o,
  output int unsigned          rsp_cnt_o,
  output logic                 idle_o
);

  // Expected completion of one consumed instruction
  typedef struct {
    bit              load;
    logic [xlen-1:0] value;
    int unsigned     parts;
  } exp_t;

  logic [7:0]  shadow [256];
  exp_t        exp_q [$];
  // Grants minus responses seen on the bus
  int unsigned outstanding;
  // Part of the present instruction being granted
  int unsigned part_idx;
  int unsigned parts_seen;
  logic        err_acc;
  // Request held over the last edge without a grant
  logic        held;

  task automatic report(input string msg);
    err_cnt_o++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  // Bytes touched over two words, low nibble in the first word
  function automatic logic [7:0] lane_mask(input logic [xlen-1:0] addr,
                                           input logic [1:0]      size);
    logic [7:0] bytes;
    case (size)
      size_byte: bytes = 8'h01;
      size_half: bytes = 8'h03;
      default:   bytes = 8'h0f;
    endcase
    return bytes << addr[1:0];
  endfunction

  // Little-endian gather from the shadow bytes, then extension
  function automatic logic [xlen-1:0] load_ref(input logic [xlen-1:0] addr,
                                               input logic [1:0]      size,
                                               input logic            sext);
    logic [xlen-1:0] v;
    int unsigned     k;
    v = '0;
    for (k = 0; k < 4; k++) begin
      if (k < (32'd1 << size)) begin
        v[8*k +: 8] = shadow[8'(addr + k)];
      end
    end
    case (size)
      size_byte: if (sext) v[31:8] = {24{v[7]}};
      size_half: if (sext) v[31:16] = {16{v[15]}};
      default: ;
    endcase
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : watch
    logic [xlen-1:0] addr;
    logic [7:0]      mask;
    logic [xlen-1:0] exp_addr;
    logic [be_w-1:0] exp_be;
    logic            exp_busy;
    logic            exp_intr;
    int unsigned     nparts;
    int unsigned     k;
    int              idx;
    exp_t            ent;
    if (!rst_n) begin
      // Same fill as the memory model
      for (k = 0; k < 256; k++) begin
        shadow[k] = 8'(k * 37 + 11);
      end
      outstanding = 0;
      part_idx    = 0;
      parts_seen  = 0;
      err_acc     = 1'b0;
      held        = 1'b0;
      idle_o      = 1'b0;
      chk_cnt_o++;
      if (data_req_i || req_ready_i || rsp_valid_i || busy_i || !interruptible_i) begin
        report("control outputs not at reset values");
      end
    end else begin
      addr   = req_i.operand_a + req_i.operand_b;
      mask   = lane_mask(addr, req_i.size);
      nparts = (mask[7:4] != 4'h0) ? 2 : 1;
      // Flags against the offered instruction and the transfers in flight
      exp_busy = req_valid_i || (outstanding != 0);
      exp_intr = !held && (outstanding == 0);
      chk_cnt_o++;
      if (busy_i !== exp_busy || interruptible_i !== exp_intr) begin
        report($sformatf("busy %0b interruptible %0b, expected %0b %0b",
                         busy_i, interruptible_i, exp_busy, exp_intr));
      end
      if (data_req_i && outstanding >= lsu_depth) begin
        report($sformatf("request raised with %0d transfers outstanding", outstanding));
      end
      // Address phase against the size/offset rule
      if (data_req_i && data_gnt_i) begin
        exp_addr = (part_idx == 0) ? addr : {addr[31:2], 2'b00} + 32'd4;
        exp_be   = (part_idx == 0) ? mask[3:0] : mask[7:4];
        chk_cnt_o++;
        if (data_i.addr !== exp_addr || data_i.be !== exp_be || data_i.we !== req_i.we) begin
          report($sformatf("part %0d addr %h be %b we %b, expected %h %b %b", part_idx,
                           data_i.addr, data_i.be, data_i.we, exp_addr, exp_be, req_i.we));
        end
        if (req_i.we) begin
          for (k = 0; k < 4; k++) begin
            idx = int'(part_idx * 4 + k) - int'(addr[1:0]);
            if (exp_be[k] && data_i.wdata[8*k +: 8] !== req_i.wdata[8*idx +: 8]) begin
              report($sformatf("write lane %0d is %h, expected %h", k,
                               data_i.wdata[8*k +: 8], req_i.wdata[8*idx +: 8]));
            end
          end
        end
        outstanding++;
      end
      // Instruction consumed on its last grant
      if (req_valid_i && req_ready_i) begin
        chk_cnt_o++;
        if (part_idx != nparts - 1) begin
          report($sformatf("instruction done after %0d grants, expected %0d",
                           part_idx + 1, nparts));
        end
        ent.load  = !req_i.we;
        ent.parts = nparts;
        ent.value = req_i.we ? '0 : load_ref(addr, req_i.size, req_i.sext);
        if (req_i.we) begin
          for (k = 0; k < (32'd1 << req_i.size); k++) begin
            shadow[8'(addr + k)] = req_i.wdata[8*k +: 8];
          end
        end
        exp_q.push_back(ent);
        cons_cnt_o++;
        part_idx = 0;
      end else if (data_req_i && data_gnt_i) begin
        part_idx++;
      end
      // Responses, errors gathered over all parts
      if (data_rvalid_i) begin
        if (outstanding == 0) begin
          report("response with no transfer outstanding");
        end else begin
          outstanding--;
        end
        parts_seen++;
        err_acc = err_acc | data_err_i;
      end
      if (data_rvalid_i && exp_q.size() != 0 && parts_seen == exp_q[0].parts) begin
        ent = exp_q.pop_front();
        chk_cnt_o++;
        if (!rsp_valid_i) begin
          report("no completion on the last response");
        end else begin
          rsp_cnt_o++;
          if (rsp_err_i !== err_acc) begin
            report($sformatf("rsp_err %b, expected %b", rsp_err_i, err_acc));
          end
          // Data only matters on an error-free load
          if (ent.load && !err_acc && rsp_rdata_i !== ent.value) begin
            report($sformatf("load data %h, expected %h", rsp_rdata_i, ent.value));
          end
        end
        parts_seen = 0;
        err_acc    = 1'b0;
      end else if (rsp_valid_i) begin
        rsp_cnt_o++;
        report("completion before the last response");
      end
      held   = data_req_i && !data_gnt_i;
      idle_o = (exp_q.size() == 0) && (outstanding == 0);
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
// Free-running 10 ns clock and active-low reset held for the first five cycles
`timescale 1ns/1ps
`default_nettype none

module clock_reset_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release just after the fifth rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: testbench/tb_top.sv
// LSU testbench top with DUT, LFSR stimulus, in-order OBI memory model and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_top import lsu_pkg::*; ();

  localparam int unsigned n_ops        = 400;
  // Eight cycles of 10 ns per instruction plus reset and drain margin
  localparam int unsigned run_limit_ns = n_ops * 8 * 10 + 2000;

  // One memory response waiting for its latency to run out
  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic            err;
    logic [1:0]      lat;
  } mem_rsp_t;

  logic            clk;
  logic            rst_n;
  logic            req_valid_i;
  lsu_req_t        req_i;
  logic            req_ready_o;
  logic            data_req_o;
  bus_req_t        data_o;
  logic            data_gnt_i;
  logic            data_rvalid_i;
  logic [xlen-1:0] data_rdata_i;
  logic            data_err_i;
  logic            rsp_valid_o;
  logic [xlen-1:0] rsp_rdata_o;
  logic            rsp_err_o;
  logic            busy_o;
  logic            interruptible_o;

  int unsigned     err_cnt;
  int unsigned     chk_cnt;
  int unsigned     cons_cnt;
  int unsigned     rsp_cnt;
  logic            idle;

  logic [31:0]     lfsr_q;
  logic [7:0]      mem [256];
  mem_rsp_t        rsp_q [$];
  // Cycles the next request is held before its grant
  logic [1:0]      gnt_wait;

  clock_reset_gen u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  lsu_top DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .data_req_o      (data_req_o),
    .data_o          (data_o),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_rdata_i    (data_rdata_i),
    .data_err_i      (data_err_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_rdata_o     (rsp_rdata_o),
    .rsp_err_o       (rsp_err_o),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o)
  );

  bus_checker u_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .req_ready_i     (req_ready_o),
    .data_req_i      (data_req_o),
    .data_i          (data_o),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_err_i),
    .rsp_valid_i     (rsp_valid_o),
    .rsp_rdata_i     (rsp_rdata_o),
    .rsp_err_i       (rsp_err_o),
    .busy_i          (busy_o),
    .interruptible_i (interruptible_o),
    .err_cnt_o       (err_cnt),
    .chk_cnt_o       (chk_cnt),
    .cons_cnt_o      (cons_cnt),
    .rsp_cnt_o       (rsp_cnt),
    .idle_o          (idle)
  );

  // Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit returned
  function automatic logic [31:0] lfsr_bits(input int unsigned n);
    logic [31:0] v;
    int unsigned b;
    v = '0;
    for (b = 0; b < n; b++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and memory model
  ////////////////////////////////////////////////////////////////////////////

  // Sample on the rising edge, drive 1 ns later
  initial begin : run
    mem_rsp_t    ent;
    lsu_req_t    nxt;
    logic [11:0] imm;
    logic [1:0]  draw;
    logic [7:0]  base;
    logic        take;
    int unsigned k;
    int unsigned issued;
    lfsr_q        = 32'h4065;
    req_valid_i   = 1'b0;
    req_i         = '0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    data_err_i    = 1'b0;
    gnt_wait      = 2'd0;
    issued        = 0;
    // Odd multiplier keeps every address bit in the fill value
    for (k = 0; k < 256; k++) begin
      mem[k] = 8'(k * 37 + 11);
    end
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      // Response phase
      if (data_rvalid_i) begin
        void'(rsp_q.pop_front());
      end
      foreach (rsp_q[j]) begin
        if (rsp_q[j].lat != 2'd0) begin
          rsp_q[j].lat = 2'(rsp_q[j].lat - 1);
        end
      end
      // Address phase, write and read at grant so order matches the bus
      if (data_req_o && data_gnt_i) begin
        base = {data_o.addr[7:2], 2'b00};
        for (k = 0; k < 4; k++) begin
          if (data_o.we && data_o.be[k]) begin
            mem[8'(base + k)] = data_o.wdata[8*k +: 8];
          end
          ent.rdata[8*k +: 8] = mem[8'(base + k)];
        end
        ent.err  = (lfsr_bits(4) == 0);
        draw     = 2'(lfsr_bits(2));
        ent.lat  = (draw == 2'd3) ? 2'd0 : draw;
        rsp_q.push_back(ent);
        draw     = 2'(lfsr_bits(2));
        gnt_wait = (draw == 2'd3) ? 2'd0 : draw;
      end else if (data_req_o && gnt_wait != 2'd0) begin
        gnt_wait = 2'(gnt_wait - 1);
      end
      take = req_valid_i && req_ready_o;
      if (take) begin
        issued++;
      end
      #1;
      data_gnt_i = (gnt_wait == 2'd0);
      if (rsp_q.size() != 0 && rsp_q[0].lat == 2'd0) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = rsp_q[0].rdata;
        data_err_i    = rsp_q[0].err;
      end else begin
        data_rvalid_i = 1'b0;
        data_rdata_i  = '0;
        data_err_i    = 1'b0;
      end
      // New instruction once the previous one left, with an idle cycle now and then
      if (take || !req_valid_i) begin
        if (issued < n_ops && lfsr_bits(2) != 0) begin
          nxt.operand_a = lfsr_bits(32);
          imm           = 12'(lfsr_bits(12));
          nxt.operand_b = {{20{imm[11]}}, imm};
          draw          = 2'(lfsr_bits(2));
          nxt.size      = (draw == 2'd3) ? size_word : draw;
          nxt.we        = 1'(lfsr_bits(1));
          nxt.sext      = 1'(lfsr_bits(1));
          nxt.wdata     = lfsr_bits(32);
          req_i         = nxt;
          req_valid_i   = 1'b1;
        end else begin
          req_valid_i = 1'b0;
        end
      end
      if (issued == n_ops && !req_valid_i && idle) begin
        break;
      end
    end
    // Let the checker see the flags settle after the last response
    repeat (2) @(posedge clk);
    $display("Checks %0d, errors %0d, instructions %0d, completions %0d",
             chk_cnt, err_cnt, cons_cnt, rsp_cnt);
    if (rsp_cnt != cons_cnt) begin
      $display("Completion count does not match the instruction count");
    end
    if (err_cnt == 0 && cons_cnt == n_ops && rsp_cnt == cons_cnt) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(run_limit_ns);
    $display("Timeout after %0t, the instructions did not all complete", $time);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
